/* compile.f */
stack_ctrl_pkg.sv
ap_ctrl.sv
addr_config.sv
qp_setup_fsm.sv
net_stats.sv
stack_ctrl_top.sv
tb_stack_ctrl.sv

/* Makefile */
# Verilator build and run of the stack control plane testbench

VERILATOR ?= verilator
TOP       ?= tb_stack_ctrl
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Errors found

.PHONY: sim clean

# build, run, then fail on a crash or on the fail message in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_stack_ctrl.sv */
// self-checking testbench for the roce stack control plane top level
`timescale 1ns/10ps

module tb_stack_ctrl;

  localparam int clk_period      = 4;
  localparam int stall_margin    = 100;  // random ready stalls plus the stall test
  localparam int traffic_cycles  = 200;  // extra stream beats after the first done
  localparam int seq_cycles      = stack_ctrl_pkg::setup_delay
                                   + 3 * (stack_ctrl_pkg::interval_cycles + 1)
                                   + stack_ctrl_pkg::run_cycles + stall_margin;
  localparam int watchdog_cycles = 2 * seq_cycles + traffic_cycles;

  logic        net_clk = 1'b0;
  logic        net_aresetn;
  logic        ap_start;
  logic        ap_idle;
  logic        ap_done;
  logic        ap_ready;
  logic [31:0] rpsn, lpsn, rqpn, lqpn;
  logic [31:0] rip, lip, rudp, rkey, len;
  logic [63:0] vaddr;
  logic [31:0] ip_address, default_gateway, arp_req_ip;
  logic        arp_req_valid;
  logic        qp_valid, qp_ready, conn_valid, conn_ready, meta_valid, meta_ready;
  logic [stack_ctrl_pkg::qp_word_w-1:0]   qp_data;
  logic [stack_ctrl_pkg::conn_word_w-1:0] conn_data;
  logic [stack_ctrl_pkg::meta_word_w-1:0] meta_data;
  logic        rx_valid, rx_ready, rx_last, tx_valid, tx_ready, tx_last;
  logic [31:0] rx_words, rx_pkts, tx_words, tx_pkts;
  logic        rx_stall;

  // scoreboard state
  int          errors = 0;
  logic [15:0] lfsr;
  logic        traffic_on;   // random stream beats
  int          qp_seen, conn_seen, meta_seen;
  int          cnt_rx_words, cnt_rx_pkts, cnt_tx_words, cnt_tx_pkts;
  int          since_rise;   // start-high cycles since reset
  logic        done_seen;
  int          stall_run;    // consecutive rx valid without ready
  logic [31:0] exp_ip;
  logic [31:0] exp_gw;
  logic [stack_ctrl_pkg::qp_word_w-1:0]   exp_qp;
  logic [stack_ctrl_pkg::conn_word_w-1:0] exp_conn;
  logic [stack_ctrl_pkg::meta_word_w-1:0] exp_meta;

  always #2 net_clk = ~net_clk;

  stack_ctrl_top uut (.*);

  ////////////////////////////////////////////////////////////////////////////
  // expected values, built field by field from the word layouts
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] byte_reverse(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = v[8*(3-i) +: 8];
    end
    return r;
  endfunction

  function automatic logic [stack_ctrl_pkg::qp_word_w-1:0] qp_expect(
    input logic [31:0] r_qpn, input logic [31:0] r_psn, input logic [31:0] l_psn,
    input logic [31:0] key, input logic [63:0] va);
    logic [stack_ctrl_pkg::qp_word_w-1:0] w;
    w         = '0;
    w[2:0]    = stack_ctrl_pkg::qp_ready_recv;
    w[26:3]   = r_qpn[23:0];
    w[50:27]  = r_psn[23:0];
    w[74:51]  = l_psn[23:0];
    w[90:75]  = key[15:0];
    w[138:91] = va[47:0];
    return w;
  endfunction

  function automatic logic [stack_ctrl_pkg::conn_word_w-1:0] conn_expect(
    input logic [31:0] l_qpn, input logic [31:0] r_qpn, input logic [31:0] r_ip,
    input logic [31:0] r_udp);
    logic [stack_ctrl_pkg::conn_word_w-1:0] w;
    w           = '0;               // 96 zero bits in the middle
    w[15:0]     = l_qpn[15:0];
    w[39:16]    = r_qpn[23:0];
    w[167:136]  = byte_reverse(r_ip);
    w[183:168]  = r_udp[15:0];
    return w;
  endfunction

  // command order is read, write, read
  function automatic logic [stack_ctrl_pkg::meta_word_w-1:0] meta_expect(
    input int idx, input logic [31:0] l_qpn, input logic [31:0] l);
    logic [stack_ctrl_pkg::meta_word_w-1:0] w;
    w = '0;                          // remote address stays zero
    if (idx == 1) begin
      w[2:0]   = stack_ctrl_pkg::op_rdma_write;
      w[74:27] = stack_ctrl_pkg::write_laddr;
    end else begin
      w[2:0]   = stack_ctrl_pkg::op_rdma_read;
    end
    w[26:3]    = l_qpn[23:0];
    w[154:123] = l;
    return w;
  endfunction

  assign exp_ip   = byte_reverse(lip);
  assign exp_gw   = {stack_ctrl_pkg::gateway_top_byte, exp_ip[23:0]};
  assign exp_qp   = qp_expect(rqpn, rpsn, lpsn, rkey, vaddr);
  assign exp_conn = conn_expect(lqpn, rqpn, rip, rudp);
  assign exp_meta = meta_expect(meta_seen, lqpn, len);

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b    = lfsr[0];
  endtask

  task automatic flag_mismatch(input string name, input logic [191:0] got,
                               input logic [191:0] exp);
    errors++;
    $display("Mismatch %s: got %0h expected %0h at %0t ns", name, got, exp, $time);
  endtask

  task automatic flag_failure(input string what);
    errors++;
    $display("failure at %0t ns: %s", $time, what);
  endtask

  // one falling edge, then fresh ready stalls and stream beats
  task automatic step_cycle();
    logic b0;
    logic b1;
    @(negedge net_clk);
    take_bit(b0);
    qp_ready = b0;
    take_bit(b0);
    conn_ready = b0;
    take_bit(b0);
    take_bit(b1);
    meta_ready = b0 | b1;  // high three cycles in four
    if (traffic_on) begin
      take_bit(rx_valid);
      take_bit(rx_ready);
      take_bit(rx_last);
      take_bit(tx_valid);
      take_bit(tx_ready);
      take_bit(tx_last);
    end
  endtask

  // reference counts, same one-cycle latency as the DUT
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      qp_seen      <= 0;
      conn_seen    <= 0;
      meta_seen    <= 0;
      cnt_rx_words <= 0;
      cnt_rx_pkts  <= 0;
      cnt_tx_words <= 0;
      cnt_tx_pkts  <= 0;
      since_rise   <= 0;
      done_seen    <= 1'b0;
      stall_run    <= 0;
    end else begin
      if (qp_valid && qp_ready) qp_seen <= qp_seen + 1;
      if (conn_valid && conn_ready) conn_seen <= conn_seen + 1;
      if (meta_valid && meta_ready) meta_seen <= meta_seen + 1;
      if (rx_valid && rx_ready) begin
        cnt_rx_words <= cnt_rx_words + 1;
        if (rx_last) cnt_rx_pkts <= cnt_rx_pkts + 1;
      end
      if (tx_valid && tx_ready) begin
        cnt_tx_words <= cnt_tx_words + 1;
        if (tx_last) cnt_tx_pkts <= cnt_tx_pkts + 1;
      end
      if (ap_start) since_rise <= since_rise + 1;
      if (ap_done) done_seen <= 1'b1;
      stall_run <= (rx_valid && !rx_ready) ? stall_run + 1 : 0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  a_reset_flags: assert property (@(posedge net_clk) $rose(net_aresetn) |->
    ap_idle && !ap_done && !qp_valid && !conn_valid && !meta_valid && !arp_req_valid)
    else flag_failure("control outputs not inactive after reset");
  a_reset_cnt: assert property (@(posedge net_clk) $rose(net_aresetn) |->
    rx_words == 0 && rx_pkts == 0 && tx_words == 0 && tx_pkts == 0 && !rx_stall)
    else flag_failure("statistics not cleared by reset");
  a_reset_ip0: assert property (@(posedge net_clk) $rose(net_aresetn) |-> ip_address == 0)
    else flag_mismatch("ip_address", $sampled(ip_address), 0);
  a_reset_ip: assert property (@(posedge net_clk) $rose(net_aresetn) |=>
    ip_address == stack_ctrl_pkg::default_local_ip)
    else flag_mismatch("ip_address", $sampled(ip_address), stack_ctrl_pkg::default_local_ip);

  // address setup on the start edge
  a_idle_fall: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    $rose(ap_start) |=> !ap_idle)
    else flag_failure("ap_idle did not fall after the start edge");
  a_arp_pulse: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    $rose(ap_start) |=> arp_req_valid ##1 !arp_req_valid)
    else flag_failure("no single-cycle arp request after the start edge");
  a_arp_ip: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    arp_req_valid |-> arp_req_ip == rip)
    else flag_mismatch("arp_req_ip", $sampled(arp_req_ip), rip);
  a_ip_addr: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    $rose(ap_start) |-> ##2 ip_address == exp_ip)
    else flag_mismatch("ip_address", $sampled(ip_address), exp_ip);
  a_gateway: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    $rose(ap_start) |-> ##2 default_gateway == exp_gw)
    else flag_mismatch("default_gateway", $sampled(default_gateway), exp_gw);

  // qp and conn words
  a_qp_data: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    qp_valid && qp_ready |-> qp_data == exp_qp)
    else flag_mismatch("qp_data", $sampled(qp_data), exp_qp);
  a_qp_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    qp_valid && !qp_ready |=> qp_valid)
    else flag_failure("qp_valid dropped before acceptance");
  a_qp_once: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    qp_valid |-> qp_seen == 0)
    else flag_failure("second queue-pair word offered");
  a_conn_data: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    conn_valid && conn_ready |-> conn_data == exp_conn)
    else flag_mismatch("conn_data", $sampled(conn_data), exp_conn);
  a_conn_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    conn_valid && !conn_ready |=> conn_valid)
    else flag_failure("conn_valid dropped before acceptance");
  a_conn_once: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    conn_valid |-> conn_seen == 0)
    else flag_failure("second connection word offered");

  // metadata commands
  a_meta_key: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    meta_valid |-> rkey[0])
    else flag_failure("metadata command issued with rkey bit 0 clear");
  a_meta_max: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    meta_valid |-> meta_seen < 3)
    else flag_failure("more than three metadata commands");
  a_meta_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    meta_valid && !meta_ready |=> meta_valid)
    else flag_failure("meta_valid dropped before acceptance");
  a_meta_data: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    meta_valid && meta_ready |-> meta_data == exp_meta)
    else flag_mismatch("meta_data", $sampled(meta_data), exp_meta);

  // kernel done handshake
  a_done_ready: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    ap_ready == ap_done)
    else flag_mismatch("ap_ready", $sampled(ap_ready), $sampled(ap_done));
  a_done_one: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    ap_done |=> !ap_done)
    else flag_failure("ap_done high two cycles in a row");
  a_done_idle: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    ap_done |=> ap_idle)
    else flag_failure("ap_idle low in the cycle after ap_done");
  a_done_first: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    ap_done && !done_seen |-> since_rise == stack_ctrl_pkg::run_cycles + 1)
    else flag_failure($sformatf("first ap_done %0d cycles after start", since_rise));

  // statistics
  a_rx_words: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    rx_words == cnt_rx_words)
    else flag_mismatch("rx_words", $sampled(rx_words), cnt_rx_words);
  a_rx_pkts: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    rx_pkts == cnt_rx_pkts)
    else flag_mismatch("rx_pkts", $sampled(rx_pkts), cnt_rx_pkts);
  a_tx_words: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    tx_words == cnt_tx_words)
    else flag_mismatch("tx_words", $sampled(tx_words), cnt_tx_words);
  a_tx_pkts: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    tx_pkts == cnt_tx_pkts)
    else flag_mismatch("tx_pkts", $sampled(tx_pkts), cnt_tx_pkts);
  a_stall_set: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    stall_run >= stack_ctrl_pkg::stall_limit + 2 |-> rx_stall)
    else flag_failure("rx_stall not set after a held receive stall");
  a_stall_early: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    $rose(rx_stall) |-> $past(stall_run) > stack_ctrl_pkg::stall_limit)
    else flag_failure("rx_stall set before the stall limit was passed");
  a_stall_keep: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    rx_stall |=> rx_stall)
    else flag_failure("rx_stall cleared without reset");

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    lfsr        = 16'd20558;
    traffic_on  = 1'b0;
    net_aresetn = 1'b0;
    ap_start    = 1'b0;
    rpsn        = 32'h00AB_CDEF;
    lpsn        = 32'h1165_4321;   // upper byte outside the field
    rqpn        = 32'hFF00_0123;
    lqpn        = 32'hAA12_3456;   // 16 bits in conn, 24 in meta
    rip         = 32'hC0A8_0107;
    lip         = 32'hC0A8_0105;
    rudp        = 32'h0000_12B7;
    vaddr       = 64'hDEAD_1234_5678_9ABC;
    rkey        = 32'h0000_BEE0;   // no rdma test on the first run
    len         = 32'h0000_1000;
    qp_ready    = 1'b0;
    conn_ready  = 1'b0;
    meta_ready  = 1'b0;
    rx_valid    = 1'b0;
    rx_ready    = 1'b0;
    rx_last     = 1'b0;
    tx_valid    = 1'b0;
    tx_ready    = 1'b0;
    tx_last     = 1'b0;
    repeat (2) @(negedge net_clk);  // two reset cycles
    net_aresetn = 1'b1;
    traffic_on  = 1'b1;
    repeat (3) step_cycle();

    // first run, qp and conn only
    ap_start = 1'b1;
    while (conn_seen == 0) step_cycle();
    while (!ap_done) step_cycle();
    repeat (traffic_cycles) step_cycle();  // no repeat of setup meanwhile

    // directed receive stall
    traffic_on = 1'b0;
    rx_valid   = 1'b1;
    rx_ready   = 1'b0;
    tx_valid   = 1'b0;
    repeat (stack_ctrl_pkg::stall_limit + 4) step_cycle();
    rx_valid = 1'b0;
    repeat (4) step_cycle();

    // second run after reset, rdma read/write/read
    net_aresetn = 1'b0;
    ap_start    = 1'b0;
    rkey        = 32'h0000_BEE1;
    repeat (2) step_cycle();
    net_aresetn = 1'b1;
    traffic_on  = 1'b1;
    repeat (3) step_cycle();
    ap_start = 1'b1;
    while (meta_seen < 3) step_cycle();
    repeat (2 * stack_ctrl_pkg::interval_cycles) step_cycle();

    $display("closing: %0d errors, %0d meta words, rx %0d/%0d tx %0d/%0d words/pkts",
             errors, meta_seen, rx_words, rx_pkts, tx_words, tx_pkts);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles, DUT never finished the sequence",
             watchdog_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

/* stack_ctrl_top.sv */
// roce stack control plane top: kernel handshake, address setup, qp setup, stats
`timescale 1ns/10ps

module stack_ctrl_top (
  input  logic                                   net_clk,
  input  logic                                   net_aresetn,
  // kernel control
  input  logic                                   ap_start,
  output logic                                   ap_idle,
  output logic                                   ap_done,
  output logic                                   ap_ready,
  // host connection parameters
  input  logic [31:0]                            rpsn,
  input  logic [31:0]                            lpsn,
  input  logic [31:0]                            rqpn,
  input  logic [31:0]                            lqpn,
  input  logic [31:0]                            rip,
  input  logic [31:0]                            lip,
  input  logic [31:0]                            rudp,
  input  logic [63:0]                            vaddr,
  input  logic [31:0]                            rkey,
  input  logic [31:0]                            len,
  // addressing
  output logic [31:0]                            ip_address,
  output logic [31:0]                            default_gateway,
  output logic                                   arp_req_valid,
  output logic [31:0]                            arp_req_ip,
  // setup commands
  output logic                                   qp_valid,
  input  logic                                   qp_ready,
  output logic [stack_ctrl_pkg::qp_word_w-1:0]   qp_data,
  output logic                                   conn_valid,
  input  logic                                   conn_ready,
  output logic [stack_ctrl_pkg::conn_word_w-1:0] conn_data,
  output logic                                   meta_valid,
  input  logic                                   meta_ready,
  output logic [stack_ctrl_pkg::meta_word_w-1:0] meta_data,
  // monitored net streams
  input  logic                                   rx_valid,
  input  logic                                   rx_ready,
  input  logic                                   rx_last,
  input  logic                                   tx_valid,
  input  logic                                   tx_ready,
  input  logic                                   tx_last,
  output logic [31:0]                            rx_words,
  output logic [31:0]                            rx_pkts,
  output logic [31:0]                            tx_words,
  output logic [31:0]                            tx_pkts,
  output logic                                   rx_stall
);

  logic start_pulse;  // ap_start rising edge

  ap_ctrl u_ap_ctrl (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .ap_start    (ap_start),
    .start_pulse (start_pulse),
    .ap_idle     (ap_idle),
    .ap_done     (ap_done),
    .ap_ready    (ap_ready)
  );

  addr_config u_addr_config (
    .net_clk         (net_clk),
    .net_aresetn     (net_aresetn),
    .start_pulse     (start_pulse),
    .lip             (lip),
    .rip             (rip),
    .ip_address      (ip_address),
    .default_gateway (default_gateway),
    .arp_req_valid   (arp_req_valid),
    .arp_req_ip      (arp_req_ip)
  );

  // sequencer works off the start level, not the edge
  qp_setup_fsm u_qp_setup_fsm (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .ap_start    (ap_start),
    .rpsn        (rpsn),
    .lpsn        (lpsn),
    .rqpn        (rqpn),
    .lqpn        (lqpn),
    .rudp        (rudp),
    .rip         (rip),
    .rkey        (rkey),
    .len         (len),
    .vaddr       (vaddr),
    .qp_ready    (qp_ready),
    .conn_ready  (conn_ready),
    .meta_ready  (meta_ready),
    .qp_valid    (qp_valid),
    .conn_valid  (conn_valid),
    .meta_valid  (meta_valid),
    .qp_data     (qp_data),
    .conn_data   (conn_data),
    .meta_data   (meta_data)
  );

  net_stats u_net_stats (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .rx_valid    (rx_valid),
    .rx_ready    (rx_ready),
    .rx_last     (rx_last),
    .tx_valid    (tx_valid),
    .tx_ready    (tx_ready),
    .tx_last     (tx_last),
    .rx_words    (rx_words),
    .rx_pkts     (rx_pkts),
    .tx_words    (tx_words),
    .tx_pkts     (tx_pkts),
    .rx_stall    (rx_stall)
  );

endmodule

/* net_stats.sv */
// network traffic statistics: rx/tx word and packet counts, sticky rx stall flag
`timescale 1ns/10ps

module net_stats (
  input  logic        net_clk,
  input  logic        net_aresetn,
  input  logic        rx_valid,
  input  logic        rx_ready,
  input  logic        rx_last,
  input  logic        tx_valid,
  input  logic        tx_ready,
  input  logic        tx_last,
  output logic [31:0] rx_words,
  output logic [31:0] rx_pkts,
  output logic [31:0] tx_words,
  output logic [31:0] tx_pkts,
  output logic        rx_stall
);

  logic [1:0]                         beat_acc;   // index 0 rx, 1 tx
  logic [1:0]                         beat_last;
  logic [stack_ctrl_pkg::stall_w-1:0] stall_cnt;  // consecutive rx stall cycles

  assign beat_acc  = {tx_valid & tx_ready, rx_valid & rx_ready};
  assign beat_last = {tx_last, rx_last};

  // same counter pair per direction
  for (genvar i = 0; i < 2; i++) begin : g_dir
    logic [31:0] words;
    logic [31:0] pkts;

    always_ff @(posedge net_clk) begin
      if (!net_aresetn) begin
        words <= '0;
        pkts  <= '0;
      end else if (beat_acc[i]) begin
        words <= words + 32'd1;
        if (beat_last[i]) begin
          pkts <= pkts + 32'd1;  // last beat closes a packet
        end
      end
    end
  end

  assign rx_words = g_dir[0].words;
  assign rx_pkts  = g_dir[0].pkts;
  assign tx_words = g_dir[1].words;
  assign tx_pkts  = g_dir[1].pkts;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      stall_cnt <= '0;
      rx_stall  <= 1'b0;
    end else begin
      if (!rx_valid || rx_ready) begin
        stall_cnt <= '0;
      end else if (stall_cnt <= stack_ctrl_pkg::stall_limit) begin
        stall_cnt <= stall_cnt + 1'b1;  // saturate one past the limit
      end
      if (stall_cnt > stack_ctrl_pkg::stall_limit) begin
        rx_stall <= 1'b1;  // sticky
      end
    end
  end

endmodule

/* qp_setup_fsm.sv */
// connection setup sequencer: qp word, conn word, then optional rdma read/write/read
`timescale 1ns/10ps

module qp_setup_fsm (
  input  logic                                   net_clk,
  input  logic                                   net_aresetn,
  input  logic                                   ap_start,
  input  logic [31:0]                            rpsn,
  input  logic [31:0]                            lpsn,
  input  logic [31:0]                            rqpn,
  input  logic [31:0]                            lqpn,
  input  logic [31:0]                            rudp,
  input  logic [31:0]                            rip,
  input  logic [31:0]                            rkey,   // bit 0 enables rdma test
  input  logic [31:0]                            len,
  input  logic [63:0]                            vaddr,
  input  logic                                   qp_ready,
  input  logic                                   conn_ready,
  input  logic                                   meta_ready,
  output logic                                   qp_valid,
  output logic                                   conn_valid,
  output logic                                   meta_valid,
  output logic [stack_ctrl_pkg::qp_word_w-1:0]   qp_data,
  output logic [stack_ctrl_pkg::conn_word_w-1:0] conn_data,
  output logic [stack_ctrl_pkg::meta_word_w-1:0] meta_data
);

  stack_ctrl_pkg::setup_state_e          state;
  logic [stack_ctrl_pkg::wait_w-1:0]     wait_cnt;    // idle delay, then meta spacing
  logic                                  setup_done;  // sticky until reset
  logic                                  in_meta;
  stack_ctrl_pkg::rdma_op_e              meta_op;
  logic [stack_ctrl_pkg::vaddr_w-1:0]    meta_laddr;
  logic [stack_ctrl_pkg::qp_word_w-1:0]  qp_word;
  logic [stack_ctrl_pkg::conn_word_w-1:0] conn_word;
  logic [stack_ctrl_pkg::meta_word_w-1:0] meta_word;

  assign in_meta = state inside {stack_ctrl_pkg::st_meta_read,
                                 stack_ctrl_pkg::st_meta_write,
                                 stack_ctrl_pkg::st_meta_read2};

  // write sits between the two reads
  always_comb begin
    if (state == stack_ctrl_pkg::st_meta_write) begin
      meta_op    = stack_ctrl_pkg::op_rdma_write;
      meta_laddr = stack_ctrl_pkg::write_laddr;
    end else begin
      meta_op    = stack_ctrl_pkg::op_rdma_read;
      meta_laddr = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // word packing, lsb field last in each concatenation
  ////////////////////////////////////////////////////////////////////////////
  assign qp_word = {5'd0,
                    vaddr[stack_ctrl_pkg::vaddr_w-1:0],
                    rkey[15:0],
                    lpsn[stack_ctrl_pkg::psn_w-1:0],
                    rpsn[stack_ctrl_pkg::psn_w-1:0],
                    rqpn[stack_ctrl_pkg::qpn_w-1:0],
                    stack_ctrl_pkg::qp_ready_recv};

  assign conn_word = {rudp[15:0],
                      rip[7:0], rip[15:8], rip[23:16], rip[31:24],  // network order
                      96'd0,
                      rqpn[stack_ctrl_pkg::qpn_w-1:0],
                      lqpn[15:0]};

  assign meta_word = {5'd0,
                      len[stack_ctrl_pkg::len_w-1:0],
                      48'd0,                               // remote addr
                      meta_laddr,
                      lqpn[stack_ctrl_pkg::qpn_w-1:0],
                      meta_op};

  ////////////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      state      <= stack_ctrl_pkg::st_idle;
      wait_cnt   <= '0;
      setup_done <= 1'b0;
      qp_valid   <= 1'b0;
      conn_valid <= 1'b0;
      meta_valid <= 1'b0;
    end else begin
      if (meta_valid && meta_ready) begin
        meta_valid <= 1'b0;  // a new word below may raise it again
      end
      case (state)
        stack_ctrl_pkg::st_idle: begin
          if (ap_start && !setup_done) begin
            wait_cnt <= wait_cnt + 1'b1;
            if (wait_cnt == stack_ctrl_pkg::setup_delay) begin
              wait_cnt <= '0;
              state    <= stack_ctrl_pkg::st_qp;
            end
          end
        end
        stack_ctrl_pkg::st_qp: begin
          qp_valid <= 1'b1;
          if (qp_valid && qp_ready) begin
            qp_valid <= 1'b0;
            state    <= stack_ctrl_pkg::st_conn;
          end
        end
        stack_ctrl_pkg::st_conn: begin
          conn_valid <= 1'b1;
          if (conn_valid && conn_ready) begin
            conn_valid <= 1'b0;
            if (rkey[0]) begin
              state <= stack_ctrl_pkg::st_meta_read;
            end else begin
              setup_done <= 1'b1;
              state      <= stack_ctrl_pkg::st_idle;
            end
          end
        end
        stack_ctrl_pkg::st_meta_read,
        stack_ctrl_pkg::st_meta_write,
        stack_ctrl_pkg::st_meta_read2: begin
          if (wait_cnt == '0) begin
            meta_valid <= 1'b1;  // offered once, at phase start
          end
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == stack_ctrl_pkg::interval_cycles) begin
            wait_cnt <= '0;
            if (state == stack_ctrl_pkg::st_meta_read) begin
              state <= stack_ctrl_pkg::st_meta_write;
            end else if (state == stack_ctrl_pkg::st_meta_write) begin
              state <= stack_ctrl_pkg::st_meta_read2;
            end else begin
              setup_done <= 1'b1;
              state      <= stack_ctrl_pkg::st_idle;
            end
          end
        end
        default: state <= stack_ctrl_pkg::st_idle;
      endcase
    end
  end

  // data regs, loaded with the rise of each valid
  always_ff @(posedge net_clk) begin
    if (state == stack_ctrl_pkg::st_qp && !qp_valid) begin
      qp_data <= qp_word;
    end
    if (state == stack_ctrl_pkg::st_conn && !conn_valid) begin
      conn_data <= conn_word;
    end
    if (in_meta && wait_cnt == '0) begin
      meta_data <= meta_word;  // may overwrite an unaccepted word
    end
  end

  a_qp_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    qp_valid && !qp_ready |=> qp_valid && $stable(qp_data))
    else $error("qp word changed before acceptance");

  a_conn_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    conn_valid && !conn_ready |=> conn_valid && $stable(conn_data))
    else $error("conn word changed before acceptance");

  // phases are strictly sequential
  a_one_cmd: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    $onehot0({qp_valid, conn_valid, meta_valid}))
    else $error("more than one command valid");

endmodule

/* addr_config.sv */
// local ipv4 address register, default gateway and host arp lookup on start
`timescale 1ns/10ps

module addr_config (
  input  logic        net_clk,
  input  logic        net_aresetn,
  input  logic        start_pulse,
  input  logic [31:0] lip,              // host byte order
  input  logic [31:0] rip,
  output logic [31:0] ip_address,       // to the stack, network order
  output logic [31:0] default_gateway,
  output logic        arp_req_valid,
  output logic [31:0] arp_req_ip
);

  logic [31:0] local_ip;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      local_ip        <= stack_ctrl_pkg::default_local_ip;
      ip_address      <= '0;
      default_gateway <= '0;
      arp_req_valid   <= 1'b0;
    end else begin
      if (start_pulse) begin
        local_ip <= {lip[7:0], lip[15:8], lip[23:16], lip[31:24]};  // byte swap
      end
      // distribution stage, one cycle behind the local register
      ip_address      <= local_ip;
      default_gateway <= {stack_ctrl_pkg::gateway_top_byte, local_ip[23:0]};
      arp_req_valid   <= start_pulse;  // no ready on the lookup port
    end
  end

  // lookup address sampled with the strobe
  always_ff @(posedge net_clk) begin
    if (start_pulse) begin
      arp_req_ip <= rip;
    end
  end

  // start_pulse is an edge, so a second request needs ap_start to drop first
  a_arp_strobe: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    arp_req_valid |=> !arp_req_valid)
    else $error("arp_req_valid longer than one cycle");

endmodule

/* ap_ctrl.sv */
// kernel control handshake: start edge detect, idle flag and run-timer done pulse
`timescale 1ns/10ps

module ap_ctrl (
  input  logic net_clk,
  input  logic net_aresetn,
  input  logic ap_start,
  output logic start_pulse,
  output logic ap_idle,
  output logic ap_done,
  output logic ap_ready
);

  logic                             start_q;  // ap_start one cycle back
  logic [stack_ctrl_pkg::run_w-1:0] run_cnt;  // start-high cycles this run

  assign start_pulse = ap_start & ~start_q;  // rising edge only
  assign ap_ready    = ap_done;              // non-pipelined kernel

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      start_q <= 1'b0;
      ap_idle <= 1'b1;
      ap_done <= 1'b0;
      run_cnt <= '0;
    end else begin
      start_q <= ap_start;

      // done wins over a fresh start
      if (ap_done) begin
        ap_idle <= 1'b1;
      end else if (start_pulse) begin
        ap_idle <= 1'b0;
      end

      // timer expiry gives one done pulse and restarts the count
      ap_done <= 1'b0;
      if (run_cnt == stack_ctrl_pkg::run_cycles) begin
        run_cnt <= '0;
        ap_done <= 1'b1;
      end else if (ap_start) begin
        run_cnt <= run_cnt + 1'b1;
      end
    end
  end

  // counter clears on expiry, so done can never be back to back
  a_done_pulse: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    ap_done |=> !ap_done)
    else $error("ap_done held for two cycles");

endmodule

/* stack_ctrl_pkg.sv */
// shared constants, field widths and encodings for the roce stack control plane
package stack_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // timers, scaled down for simulation
  ////////////////////////////////////////////////////////////////////////////
  localparam int run_cycles      = 64;  // start-high cycles per done pulse
  localparam int setup_delay     = 40;  // start-high cycles before qp write
  localparam int interval_cycles = 16;  // spacing of metadata commands
  localparam int stall_limit     = 2;   // rx stall threshold

  localparam int run_w   = $clog2(run_cycles + 1);
  // shared wait counter, setup delay is the longer of the two waits
  localparam int wait_w  = $clog2(setup_delay + 1);
  localparam int stall_w = $clog2(stall_limit + 2);  // saturates one past limit

  // addressing
  localparam logic [31:0] default_local_ip = 32'hD1D4010B;
  localparam logic [7:0]  gateway_top_byte = 8'h01;

  // command word widths
  localparam int qp_word_w   = 144;
  localparam int conn_word_w = 184;
  localparam int meta_word_w = 160;

  // field widths
  localparam int qpn_w   = 24;
  localparam int psn_w   = 24;
  localparam int vaddr_w = 48;  // also local and remote buffer address
  localparam int len_w   = 32;

  localparam logic [vaddr_w-1:0] write_laddr = 48'h10;  // rdma write source

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    st_idle,
    st_qp,
    st_conn,
    st_meta_read,
    st_meta_write,
    st_meta_read2
  } setup_state_e;

  typedef enum logic [2:0] {
    op_rdma_read  = 3'd0,
    op_rdma_write = 3'd1
  } rdma_op_e;

  typedef enum logic [2:0] {
    qp_ready_recv = 3'd2  // only state the host ever writes
  } qp_state_e;

endpackage
